//--- common/snn_pkg.sv
package snn_pkg;

    // array and time step geometry
    localparam int UNIT_NUM   = 4;
    localparam int TIME_STEPS = 4;
    localparam int LANE_W     = 20;
    localparam int SUM_W      = LANE_W + 2;

    // burst and bias table layout
    localparam int BURST_LEN         = UNIT_NUM * UNIT_NUM;
    localparam int BLOCKS            = 4;
    localparam int BIAS_DEPTH        = 64;
    localparam int LAYER_BIAS_STRIDE = BLOCKS * UNIT_NUM;
    localparam int BIAS_W            = 16;

    // spike packing, two bits per time step and one field per psum word
    localparam int SPIKES_PER_WORD = 8;
    localparam int FIELD_W         = 2 * TIME_STEPS;

    localparam int CNT_W   = $clog2(BURST_LEN);
    localparam int GRP_W   = $clog2(UNIT_NUM);
    localparam int BLK_W   = $clog2(BLOCKS);
    localparam int IDX_W   = $clog2(SPIKES_PER_WORD);
    localparam int THRD_W  = 24;
    localparam int LAYERS  = 4;

    typedef logic [TIME_STEPS-1:0][LANE_W-1:0] psum_t;
    typedef logic signed [BIAS_W-1:0]          bias_t;
    typedef logic [$clog2(BIAS_DEPTH)-1:0]     bias_addr_t;
    typedef logic [TIME_STEPS-1:0][SUM_W-1:0]  sum_t;
    typedef logic [UNIT_NUM-1:0]               grant_t;
    typedef logic [$clog2(LAYERS)-1:0]         layer_t;
    typedef logic signed [THRD_W-1:0]          thrd_t;
    typedef logic [SPIKES_PER_WORD*FIELD_W-1:0] wr_word_t;
    typedef logic [5:0]                        wr_addr_t;

    // firing threshold per layer
    localparam thrd_t LAYER_THRD [LAYERS] = '{
        thrd_t'(128),
        thrd_t'(256),
        thrd_t'(128),
        thrd_t'(128)
    };

endpackage

//--- hw/psum_fetch_seq.sv
`timescale 1ns/100ps

module psum_fetch_seq import snn_pkg::*; (
    input  logic             s_clk,
    input  logic             s_rst,
    input  logic             i_start,
    input  layer_t           i_layer,
    input  logic             i_finish_q,
    input  logic             i_finish_k,
    input  logic             i_finish_v,
    output grant_t           o_psum_grant,
    output logic             o_psum_valid,
    output logic             o_burst_done,
    output logic             o_rd_en,
    output layer_t           o_rd_layer,
    output logic [BLK_W-1:0] o_rd_block,
    output logic [GRP_W-1:0] o_rd_group
);

    logic [2:0]       r_finish;
    logic [2:0]       w_finish_all;
    logic             w_burst_start;
    logic             w_burst_last;
    logic [CNT_W-1:0] r_cnt;
    logic [BLK_W-1:0] r_block;
    layer_t           r_layer;

    // a pulse arriving this cycle counts, so the burst starts right after it
    assign w_finish_all  = r_finish | {i_finish_v, i_finish_k, i_finish_q};
    assign w_burst_start = (&w_finish_all) && !o_psum_valid;
    assign w_burst_last  = o_psum_valid && (r_cnt == CNT_W'(BURST_LEN - 1));

    // sticky finish flags
    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            r_finish <= '0;
        end else if (i_start || w_burst_start) begin
            r_finish <= '0;
        end else begin
            r_finish <= w_finish_all;
        end
    end

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            o_psum_valid <= 1'b0;
            o_psum_grant <= '0;
            o_burst_done <= 1'b0;
            r_cnt        <= '0;
        end else begin
            o_burst_done <= w_burst_last;
            if (w_burst_start) begin
                o_psum_valid <= 1'b1;
                o_psum_grant <= grant_t'(1);
                r_cnt        <= '0;
            end else if (w_burst_last) begin
                o_psum_valid <= 1'b0;
                o_psum_grant <= '0;
                r_cnt        <= '0;
            end else if (o_psum_valid) begin
                r_cnt <= r_cnt + 1'b1;
                // next unit after every UNIT_NUM words
                if (r_cnt[GRP_W-1:0] == GRP_W'(UNIT_NUM - 1)) begin
                    o_psum_grant <= {o_psum_grant[UNIT_NUM-2:0], o_psum_grant[UNIT_NUM-1]};
                end
            end
        end
    end

    // block count and layer for bias lookup
    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            r_block <= '0;
            r_layer <= '0;
        end else if (i_start) begin
            r_block <= '0;
            r_layer <= i_layer;
        end else if (w_burst_last) begin
            r_block <= (r_block == BLK_W'(BLOCKS - 1)) ? '0 : r_block + 1'b1;
        end
    end

    assign o_rd_en    = o_psum_valid;
    assign o_rd_layer = r_layer;
    assign o_rd_block = r_block;
    assign o_rd_group = r_cnt[CNT_W-1:CNT_W-GRP_W];

endmodule

//--- hw/bias_table.sv
`timescale 1ns/100ps

module bias_table import snn_pkg::*; (
    input  logic             s_clk,
    input  logic             s_rst,
    input  logic             i_we,
    input  bias_addr_t       i_waddr,
    input  bias_t            i_wdata,
    input  logic             i_rd_en,
    input  layer_t           i_rd_layer,
    input  logic [BLK_W-1:0] i_rd_block,
    input  logic [GRP_W-1:0] i_rd_group,
    output bias_t            o_bias,
    output logic             o_bias_valid
);

    bias_t      mem [BIAS_DEPTH];
    bias_addr_t w_rd_addr;

    // layer base, then block, then group within block
    assign w_rd_addr = bias_addr_t'(i_rd_layer * LAYER_BIAS_STRIDE
                                    + i_rd_block * UNIT_NUM
                                    + i_rd_group);

    always_ff @(posedge s_clk) begin
        if (i_we) begin
            mem[i_waddr] <= i_wdata;
        end
    end

    always_ff @(posedge s_clk) begin
        if (i_rd_en) begin
            o_bias <= mem[w_rd_addr];
        end
    end

    // lines up with the registered psums in the adder tree
    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            o_bias_valid <= 1'b0;
        end else begin
            o_bias_valid <= i_rd_en;
        end
    end

endmodule

//--- combine/psum_add_tree.sv
`timescale 1ns/100ps

module psum_add_tree import snn_pkg::*; (
    input  logic  s_clk,
    input  logic  s_rst,
    input  logic  i_psum_valid,
    input  psum_t i_psum_q,
    input  psum_t i_psum_k,
    input  psum_t i_psum_v,
    input  bias_t i_bias,
    input  logic  i_bias_valid,
    output sum_t  o_sum,
    output logic  o_sum_valid
);

    psum_t                     r_psum_q;
    psum_t                     r_psum_k;
    psum_t                     r_psum_v;
    logic                      r_psum_valid;
    logic signed [LANE_W-1:0]  w_bias_ext;
    sum_t                      w_sum;

    always_ff @(posedge s_clk) begin
        if (i_psum_valid) begin
            r_psum_q <= i_psum_q;
            r_psum_k <= i_psum_k;
            r_psum_v <= i_psum_v;
        end
    end

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            r_psum_valid <= 1'b0;
        end else begin
            r_psum_valid <= i_psum_valid;
        end
    end

    assign w_bias_ext = {{(LANE_W - BIAS_W){i_bias[BIAS_W-1]}}, i_bias};

    // four-input signed add per time step
    always_comb begin
        for (int t = 0; t < TIME_STEPS; t++) begin
            w_sum[t] = SUM_W'($signed(r_psum_q[t])) + SUM_W'($signed(r_psum_k[t]))
                     + SUM_W'($signed(r_psum_v[t])) + SUM_W'(w_bias_ext);
        end
    end

    always_ff @(posedge s_clk) begin
        o_sum <= w_sum;
    end

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            o_sum_valid <= 1'b0;
        end else begin
            o_sum_valid <= r_psum_valid && i_bias_valid;
        end
    end

endmodule

//--- combine/lif_spike_pack.sv
`timescale 1ns/100ps

module lif_spike_pack import snn_pkg::*; (
    input  logic     s_clk,
    input  logic     s_rst,
    input  logic     i_start,
    input  layer_t   i_layer,
    input  sum_t     i_sum,
    input  logic     i_sum_valid,
    output logic     o_wr_en,
    output wr_addr_t o_wr_addr,
    output wr_word_t o_wr_data
);

    thrd_t              r_thrd;
    logic [FIELD_W-1:0] w_field;
    logic [FIELD_W-1:0] r_spk;
    logic               r_spk_valid;
    logic [IDX_W-1:0]   r_idx;
    wr_word_t           r_buf;
    wr_word_t           w_word;

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            r_thrd <= LAYER_THRD[0];
        end else if (i_start) begin
            r_thrd <= LAYER_THRD[i_layer];
        end
    end

    // integrate and fire across time steps, membrane restarts at zero per word
    always_comb begin
        thrd_t v_mem;
        v_mem   = '0;
        w_field = '0;
        for (int t = 0; t < TIME_STEPS; t++) begin
            v_mem = v_mem + thrd_t'($signed(i_sum[t]));
            if (v_mem >= r_thrd) begin
                w_field[2*t] = 1'b1;
                v_mem        = '0;
            end
        end
    end

    always_ff @(posedge s_clk) begin
        if (i_sum_valid) begin
            r_spk <= w_field;
        end
    end

    // drop the new field into its slot
    always_comb begin
        w_word = r_buf;
        w_word[r_idx*FIELD_W +: FIELD_W] = r_spk;
    end

    always_ff @(posedge s_clk) begin
        if (r_spk_valid) begin
            r_buf <= w_word;
            if (r_idx == IDX_W'(SPIKES_PER_WORD - 1)) begin
                o_wr_data <= w_word;
            end
        end
    end

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            r_spk_valid <= 1'b0;
            r_idx       <= '0;
            o_wr_en     <= 1'b0;
            o_wr_addr   <= '0;
        end else begin
            r_spk_valid <= i_sum_valid;
            o_wr_en     <= 1'b0;
            if (i_start) begin
                r_idx     <= '0;
                o_wr_addr <= '0;
            end else begin
                // address moves on once the write has gone out
                if (o_wr_en) begin
                    o_wr_addr <= o_wr_addr + 1'b1;
                end
                if (r_spk_valid) begin
                    r_idx <= r_idx + 1'b1;
                    if (r_idx == IDX_W'(SPIKES_PER_WORD - 1)) begin
                        o_wr_en <= 1'b1;
                    end
                end
            end
        end
    end

endmodule

//--- hw/snn_psum_unit.sv
`timescale 1ns/100ps

module snn_psum_unit import snn_pkg::*; (
    input  logic       s_clk,
    input  logic       s_rst,
    input  logic       i_start,
    input  layer_t     i_layer,
    input  logic       i_finish_q,
    input  logic       i_finish_k,
    input  logic       i_finish_v,
    input  psum_t      i_psum_q,
    input  psum_t      i_psum_k,
    input  psum_t      i_psum_v,
    input  logic       i_bias_we,
    input  bias_addr_t i_bias_waddr,
    input  bias_t      i_bias_wdata,
    output grant_t     o_psum_grant,
    output logic       o_psum_valid,
    output logic       o_burst_done,
    output logic       o_wr_en,
    output wr_addr_t   o_wr_addr,
    output wr_word_t   o_wr_data
);

    logic             w_rd_en;
    layer_t           w_rd_layer;
    logic [BLK_W-1:0] w_rd_block;
    logic [GRP_W-1:0] w_rd_group;
    bias_t            w_bias;
    logic             w_bias_valid;
    sum_t             w_sum;
    logic             w_sum_valid;

    psum_fetch_seq u_psum_fetch_seq (
        .s_clk        (s_clk),
        .s_rst        (s_rst),
        .i_start      (i_start),
        .i_layer      (i_layer),
        .i_finish_q   (i_finish_q),
        .i_finish_k   (i_finish_k),
        .i_finish_v   (i_finish_v),
        .o_psum_grant (o_psum_grant),
        .o_psum_valid (o_psum_valid),
        .o_burst_done (o_burst_done),
        .o_rd_en      (w_rd_en),
        .o_rd_layer   (w_rd_layer),
        .o_rd_block   (w_rd_block),
        .o_rd_group   (w_rd_group)
    );

    bias_table u_bias_table (
        .s_clk        (s_clk),
        .s_rst        (s_rst),
        .i_we         (i_bias_we),
        .i_waddr      (i_bias_waddr),
        .i_wdata      (i_bias_wdata),
        .i_rd_en      (w_rd_en),
        .i_rd_layer   (w_rd_layer),
        .i_rd_block   (w_rd_block),
        .i_rd_group   (w_rd_group),
        .o_bias       (w_bias),
        .o_bias_valid (w_bias_valid)
    );

    psum_add_tree u_psum_add_tree (
        .s_clk        (s_clk),
        .s_rst        (s_rst),
        .i_psum_valid (o_psum_valid),
        .i_psum_q     (i_psum_q),
        .i_psum_k     (i_psum_k),
        .i_psum_v     (i_psum_v),
        .i_bias       (w_bias),
        .i_bias_valid (w_bias_valid),
        .o_sum        (w_sum),
        .o_sum_valid  (w_sum_valid)
    );

    lif_spike_pack u_lif_spike_pack (
        .s_clk       (s_clk),
        .s_rst       (s_rst),
        .i_start     (i_start),
        .i_layer     (i_layer),
        .i_sum       (w_sum),
        .i_sum_valid (w_sum_valid),
        .o_wr_en     (o_wr_en),
        .o_wr_addr   (o_wr_addr),
        .o_wr_data   (o_wr_data)
    );

endmodule

//--- tests/snn_psum_unit_props.sv
`timescale 1ns/100ps

module snn_psum_unit_props import snn_pkg::*; (
    input logic   s_clk,
    input logic   s_rst,
    input grant_t i_psum_grant,
    input logic   i_psum_valid,
    input logic   i_burst_done
);

    int fail_cnt = 0;

    // each fetched word comes from exactly one unit
    a_grant_onehot: assert property (@(posedge s_clk) disable iff (s_rst)
        i_psum_valid |-> $onehot(i_psum_grant))
    else begin
        $error("grant is not one-hot while valid");
        fail_cnt = fail_cnt + 1;
    end

    a_grant_idle: assert property (@(posedge s_clk) disable iff (s_rst)
        !i_psum_valid |-> (i_psum_grant == '0))
    else begin
        $error("grant is not zero while idle");
        fail_cnt = fail_cnt + 1;
    end

    a_done_apart: assert property (@(posedge s_clk) disable iff (s_rst)
        !(i_burst_done && i_psum_valid))
    else begin
        $error("burst done coincides with valid");
        fail_cnt = fail_cnt + 1;
    end

endmodule

bind psum_fetch_seq snn_psum_unit_props u_fetch_props (
    .s_clk        (s_clk),
    .s_rst        (s_rst),
    .i_psum_grant (o_psum_grant),
    .i_psum_valid (o_psum_valid),
    .i_burst_done (o_burst_done)
);

//--- tests/tb_snn_psum_unit.sv
`timescale 1ns/100ps

module tb_snn_psum_unit import snn_pkg::*; ();

    // five tests of about four bursts, 100 cycles per burst with its share of bias loads
    localparam int TIMEOUT_CYCLES = 5 * 4 * 100;

    logic        s_clk = 1'b0;
    logic        s_rst;
    logic        i_start;
    layer_t      i_layer;
    logic        i_finish_q;
    logic        i_finish_k;
    logic        i_finish_v;
    psum_t       i_psum_q;
    psum_t       i_psum_k;
    psum_t       i_psum_v;
    logic        i_bias_we;
    bias_addr_t  i_bias_waddr;
    bias_t       i_bias_wdata;
    grant_t      o_psum_grant;
    logic        o_psum_valid;
    logic        o_burst_done;
    logic        o_wr_en;
    wr_addr_t    o_wr_addr;
    wr_word_t    o_wr_data;

    // array data for the next burst and a mirror of the bias table
    psum_t       q_mem [BURST_LEN];
    psum_t       k_mem [BURST_LEN];
    psum_t       v_mem [BURST_LEN];
    bias_t       bias_model [BIAS_DEPTH];
    wr_word_t    wr_data_q [$];
    wr_addr_t    wr_addr_q [$];
    int          wr_due_q [$];
    logic [31:0] lfsr_state = 32'h48fc9e9a;
    layer_t      cur_layer;
    int          model_block;
    wr_addr_t    next_addr;
    int          fetch_cnt = 0;
    int          last_burst_len = 0;
    int          valid_total = 0;
    int          done_cnt = 0;
    int          cycle_cnt = 0;

    snn_psum_unit i_snn_psum_unit (.*);

    always #20 s_clk = ~s_clk;

    always @(posedge s_clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, the DUT stopped responding", cycle_cnt);
            abort_run();
        end
    end

    // array models answer the granted word, write port always accepts
    always @(negedge s_clk) begin
        if (o_psum_valid) begin
            if (fetch_cnt >= BURST_LEN) begin
                $display("o_psum_valid stayed high for more than %0d cycles", BURST_LEN);
                abort_run();
            end
            check_grant(o_psum_grant, grant_t'(1 << (fetch_cnt / UNIT_NUM)));
            i_psum_q = q_mem[fetch_cnt];
            i_psum_k = k_mem[fetch_cnt];
            i_psum_v = v_mem[fetch_cnt];
            // write goes out four cycles after the last word of a half burst
            if (fetch_cnt % SPIKES_PER_WORD == SPIKES_PER_WORD - 1) begin
                wr_due_q.push_back(cycle_cnt + 4);
            end
            fetch_cnt = fetch_cnt + 1;
            valid_total = valid_total + 1;
        end else begin
            if (fetch_cnt != 0) begin
                last_burst_len = fetch_cnt;
                if (!o_burst_done) begin
                    $display("o_burst_done did not pulse on the cycle after the last valid");
                    abort_run();
                end
            end
            fetch_cnt = 0;
            check_grant(o_psum_grant, '0);
        end
        if (o_burst_done) begin
            done_cnt = done_cnt + 1;
        end
        if (o_wr_en) begin
            if (wr_due_q.size() == 0 || wr_due_q.pop_front() != cycle_cnt) begin
                $display("o_wr_en pulsed at cycle %0d, not four cycles after its half burst",
                         cycle_cnt);
                abort_run();
            end
            wr_data_q.push_back(o_wr_data);
            wr_addr_q.push_back(o_wr_addr);
        end
    end

    task automatic abort_run();
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_grant(input grant_t actual, input grant_t expected);
        if (actual !== expected) begin
            $display("** Error: o_psum_grant = 0x%h, expected 0x%h", actual, expected);
            abort_run();
        end
    endtask

    task automatic check_word(input wr_word_t actual, input wr_word_t expected);
        if (actual !== expected) begin
            $display("** Error: o_wr_data = 0x%h, expected 0x%h", actual, expected);
            abort_run();
        end
    endtask

    task automatic check_addr(input wr_addr_t actual, input wr_addr_t expected);
        if (actual !== expected) begin
            $display("** Error: o_wr_addr = 0x%h, expected 0x%h", actual, expected);
            abort_run();
        end
    endtask

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic int rand_signed(input int width);
        int v;
        v = 0;
        for (int i = 0; i < width; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = (v << 1) | lfsr_state[0];
        end
        if (v >= (1 << (width - 1))) begin
            v = v - (1 << width);
        end
        return v;
    endfunction

    function automatic psum_t make_psum(input int l0, input int l1, input int l2, input int l3);
        psum_t p;
        p[0] = LANE_W'(l0);
        p[1] = LANE_W'(l1);
        p[2] = LANE_W'(l2);
        p[3] = LANE_W'(l3);
        return p;
    endfunction

    function automatic int lane_value(input psum_t p, input int t);
        logic signed [LANE_W-1:0] lane;
        lane = p[t];
        return lane;
    endfunction

    // reference integrate and fire for one half burst
    function automatic wr_word_t expect_word(input layer_t layer, input int block, input int half);
        wr_word_t word;
        bias_t    bias;
        int       n;
        int       mem;
        int       thrd;
        word = '0;
        thrd = (layer == 1) ? 256 : 128;
        for (int j = 0; j < SPIKES_PER_WORD; j++) begin
            n    = half * SPIKES_PER_WORD + j;
            bias = bias_model[int'(layer) * 16 + block * 4 + n / 4];
            mem  = 0;
            for (int t = 0; t < TIME_STEPS; t++) begin
                mem = mem + lane_value(q_mem[n], t) + lane_value(k_mem[n], t)
                    + lane_value(v_mem[n], t) + int'(bias);
                if (mem >= thrd) begin
                    word[j * 8 + 2 * t] = 1'b1;
                    mem = 0;
                end
            end
        end
        return word;
    endfunction

    task automatic load_bias(input bias_addr_t addr, input bias_t data);
        @(negedge s_clk);
        i_bias_we    = 1'b1;
        i_bias_waddr = addr;
        i_bias_wdata = data;
        bias_model[addr] = data;
        @(negedge s_clk);
        i_bias_we = 1'b0;
    endtask

    task automatic start_layer(input layer_t layer);
        @(negedge s_clk);
        i_start = 1'b1;
        i_layer = layer;
        @(negedge s_clk);
        i_start     = 1'b0;
        cur_layer   = layer;
        model_block = 0;
        next_addr   = '0;
    endtask

    task automatic pulse_finish(input int unit);
        @(negedge s_clk);
        i_finish_q = (unit == 0);
        i_finish_k = (unit == 1);
        i_finish_v = (unit == 2);
        @(negedge s_clk);
        i_finish_q = 1'b0;
        i_finish_k = 1'b0;
        i_finish_v = 1'b0;
    endtask

    task automatic run_burst(input int first, input int second, input int third);
        int done_before;
        done_before = done_cnt;
        pulse_finish(first);
        pulse_finish(second);
        pulse_finish(third);
        if (!o_psum_valid) begin
            $display("burst did not start one cycle after the last finish pulse");
            abort_run();
        end
        while (done_cnt == done_before) @(negedge s_clk);
        while (wr_data_q.size() < 2) @(negedge s_clk);
        if (last_burst_len != BURST_LEN || done_cnt != done_before + 1) begin
            $display("burst ran %0d valid cycles with %0d done pulses",
                     last_burst_len, done_cnt - done_before);
            abort_run();
        end
        for (int h = 0; h < 2; h++) begin
            check_word(wr_data_q.pop_front(), expect_word(cur_layer, model_block, h));
            check_addr(wr_addr_q.pop_front(), next_addr);
            next_addr = next_addr + 1'b1;
        end
        model_block = (model_block + 1) % BLOCKS;
    endtask

    task automatic fill_random_psums();
        for (int n = 0; n < BURST_LEN; n++) begin
            for (int t = 0; t < TIME_STEPS; t++) begin
                q_mem[n][t] = LANE_W'(rand_signed(8));
                k_mem[n][t] = LANE_W'(rand_signed(8));
                v_mem[n][t] = LANE_W'(rand_signed(8));
            end
        end
    endtask

    task automatic reset_and_idle();
        int valid_before;
        @(negedge s_clk);
        if (o_psum_valid || o_wr_en || o_burst_done) begin
            $display("outputs are not idle after reset");
            abort_run();
        end
        start_layer(0);
        valid_before = valid_total;
        pulse_finish(0);
        pulse_finish(1);
        repeat (10) @(negedge s_clk);
        if (valid_total != valid_before) begin
            $display("a burst started after only two finish pulses");
            abort_run();
        end
    endtask

    task automatic grant_sequence();
        for (int n = 0; n < BURST_LEN; n++) begin
            q_mem[n] = '0;
            k_mem[n] = '0;
            v_mem[n] = '0;
        end
        start_layer(0);
        run_burst(2, 0, 1);
    endtask

    task automatic zero_bias_sums();
        for (int n = 0; n < BURST_LEN; n++) begin
            q_mem[n] = '0;
            k_mem[n] = '0;
            v_mem[n] = '0;
            case (n % 4)
                0: begin
                    q_mem[n] = make_psum(100 + n, 0, 0, 0);
                    k_mem[n] = make_psum(40, 0, 0, 0);
                end
                // 45 per step, fires at step 2
                1: begin
                    q_mem[n] = make_psum(15, 15, 15, 15);
                    k_mem[n] = make_psum(15, 15, 15, 15);
                    v_mem[n] = make_psum(15, 15, 15, 15);
                end
                2: begin
                    q_mem[n] = make_psum(-50, -50, -50, -50);
                    v_mem[n] = make_psum(-n, -n, -n, -n);
                end
                default: begin
                    q_mem[n] = make_psum(-100, 300, 0, 128);
                end
            endcase
        end
        start_layer(0);
        run_burst(0, 1, 2);
    endtask

    task automatic bias_addressing();
        int b;
        for (int a = 0; a < BIAS_DEPTH; a++) begin
            // only layer 1 entries can fire
            b = (a / 16 == 1) ? 20 * (a % 16) + 10 : -200 - a;
            load_bias(bias_addr_t'(a), bias_t'(b));
        end
        for (int n = 0; n < BURST_LEN; n++) begin
            q_mem[n] = make_psum(n, n, n, n);
            k_mem[n] = '0;
            v_mem[n] = '0;
        end
        start_layer(1);
        for (int blk = 0; blk < BLOCKS + 1; blk++) begin
            run_burst(blk % 3, (blk + 1) % 3, (blk + 2) % 3);
        end
    endtask

    task automatic random_threshold_pack();
        for (int l = 0; l < 2; l++) begin
            for (int a = 0; a < BIAS_DEPTH; a++) begin
                load_bias(bias_addr_t'(a), bias_t'(rand_signed(7)));
            end
            start_layer(layer_t'(l));
            for (int blk = 0; blk < 2; blk++) begin
                fill_random_psums();
                run_burst(1, 2, 0);
            end
        end
    endtask

    initial begin
        s_rst        = 1'b1;
        i_start      = 1'b0;
        i_layer      = '0;
        i_finish_q   = 1'b0;
        i_finish_k   = 1'b0;
        i_finish_v   = 1'b0;
        i_psum_q     = '0;
        i_psum_k     = '0;
        i_psum_v     = '0;
        i_bias_we    = 1'b0;
        i_bias_waddr = '0;
        i_bias_wdata = '0;
        cur_layer    = '0;
        model_block  = 0;
        next_addr    = '0;
        repeat (5) @(posedge s_clk);
        @(negedge s_clk);
        s_rst = 1'b0;

        reset_and_idle();
        // bias memory powers up unknown
        for (int a = 0; a < BIAS_DEPTH; a++) begin
            load_bias(bias_addr_t'(a), '0);
        end
        grant_sequence();
        zero_bias_sums();
        bias_addressing();
        random_threshold_pack();

        repeat (4) @(negedge s_clk);
        if (i_snn_psum_unit.u_psum_fetch_seq.u_fetch_props.fail_cnt == 0) begin
            $display("TEST OK");
            $finish;
        end else begin
            $display("assertions failed in the fetch sequencer");
            abort_run();
        end
    end

endmodule

//--- sim.f
common/snn_pkg.sv
hw/psum_fetch_seq.sv
hw/bias_table.sv
combine/psum_add_tree.sv
combine/lif_spike_pack.sv
hw/snn_psum_unit.sv
tests/snn_psum_unit_props.sv
tests/tb_snn_psum_unit.sv

//--- Bender.yml
package:
  name: snn_psum_unit

sources:
  - common/snn_pkg.sv
  - hw/psum_fetch_seq.sv
  - hw/bias_table.sv
  - combine/psum_add_tree.sv
  - combine/lif_spike_pack.sv
  - hw/snn_psum_unit.sv
  - target: test
    files:
      - tests/snn_psum_unit_props.sv
      - tests/tb_snn_psum_unit.sv
